/* logic/car_sim_pkg.sv */
`default_nettype none

package car_sim_pkg;

    // register bus and ADC sample word.
    typedef logic [15:0] sim_word_t;
    typedef logic [3:0] reg_addr_t;

    // register map of the host bus.
    localparam reg_addr_t REG_IGN_PERIOD = 4'd0;
    // a write to either count address clears that count.
    localparam reg_addr_t REG_IGN_CYCLE_CNT = 4'd1;
    localparam reg_addr_t REG_PUFF_CNT = 4'd2;
    localparam reg_addr_t REG_PUFF_LEN = 4'd3;
    localparam reg_addr_t REG_ANMUX_BLOCK_TEMP = 4'd4;
    localparam reg_addr_t REG_ANMUX_TRANS_TEMP = 4'd5;
    localparam reg_addr_t REG_ADC_MAF = 4'd6;
    localparam reg_addr_t REG_ADC_O2 = 4'd7;
    localparam reg_addr_t REG_ADC_TPS = 4'd8;

    // one write on the host bus that takes effect when load is high.
    typedef struct packed {
        logic load;
        reg_addr_t addr;
        sim_word_t data;
    } reg_write_t;

    typedef logic [2:0] adc_channel_t;
    typedef logic [3:0] anmux_sel_t;

    // ADC channels wired to car sensors.
    localparam adc_channel_t ADC_CH_MAF = 3'd4;
    localparam adc_channel_t ADC_CH_O2 = 3'd5;
    localparam adc_channel_t ADC_CH_TPS = 3'd6;
    // this channel reads whatever the analog mux selects.
    localparam adc_channel_t ADC_CH_ANMUX = 3'd7;

    // analog mux inputs that carry temperatures.
    localparam anmux_sel_t ANMUX_CH_BLOCK_TEMP = 4'd2;
    localparam anmux_sel_t ANMUX_CH_TRANS_TEMP = 4'd3;

    // SPI command word seen raw by the shifter and by field at capture.
    typedef union packed {
        sim_word_t raw;
        struct packed {
            logic [1:0] unused_hi;
            adc_channel_t channel;
            logic [10:0] unused_lo;
        } fields;
    } adc_command_u;

    // single-cycle time strobes.
    typedef struct packed {
        logic us;
        logic jiffy;
        logic ms;
    } sim_ticks_t;

    // event sources offered to the target side.
    typedef struct packed {
        logic ign_end;
        logic puff_end;
        logic spi_done;
        logic puff_timeout;
    } sim_events_t;

    // host-written analog values.
    typedef struct packed {
        sim_word_t maf;
        sim_word_t o2;
        sim_word_t tps;
        sim_word_t block_temp;
        sim_word_t trans_temp;
    } adc_values_t;

    // coil stays on for this many jiffies at the end of each period.
    localparam int unsigned IGN_PULSE_JIFFIES = 16;

endpackage

`default_nettype wire

/* logic/tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_gen import car_sim_pkg::*; #(
    parameter int unsigned CLK_PER_US = 50,
    parameter int unsigned US_PER_JIFFY = 20,
    parameter int unsigned US_PER_MS = 1000
) (
    input wire logic sysclk,
    input wire logic sim_reset,
    output sim_ticks_t ticks
);

    // counter widths hold the last count value.
    localparam int US_W = $clog2(CLK_PER_US + 1);
    localparam int JIFFY_W = $clog2(US_PER_JIFFY + 1);
    localparam int MS_W = $clog2(US_PER_MS + 1);
    localparam logic [US_W-1:0] US_LAST = US_W'(CLK_PER_US - 1);
    localparam logic [JIFFY_W-1:0] JIFFY_LAST = JIFFY_W'(US_PER_JIFFY - 1);
    localparam logic [MS_W-1:0] MS_LAST = MS_W'(US_PER_MS - 1);

    logic [US_W-1:0] us_cnt;
    logic [JIFFY_W-1:0] jiffy_cnt;
    logic [MS_W-1:0] ms_cnt;
    logic us_tick;

    // first tick comes CLK_PER_US-1 cycles after reset.
    assign us_tick = (us_cnt == US_LAST);

    // sysclk cycles within one microsecond.
    always_ff @(posedge sysclk) begin
        if (sim_reset)
            us_cnt <= '0;
        else if (us_tick)
            us_cnt <= '0;
        else
            us_cnt <= us_cnt + US_W'(1);
    end

    // jiffy and ms counters both step on us ticks.
    always_ff @(posedge sysclk) begin
        if (sim_reset) begin
            jiffy_cnt <= '0;
            ms_cnt <= '0;
        end else if (us_tick) begin
            jiffy_cnt <= (jiffy_cnt == JIFFY_LAST) ? '0 : jiffy_cnt + JIFFY_W'(1);
            ms_cnt <= (ms_cnt == MS_LAST) ? '0 : ms_cnt + MS_W'(1);
        end
    end

    assign ticks.us = us_tick;
    assign ticks.jiffy = us_tick && (jiffy_cnt == JIFFY_LAST);
    assign ticks.ms = us_tick && (ms_cnt == MS_LAST);

endmodule

`default_nettype wire

/* logic/sim_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module sim_reg_file import car_sim_pkg::*; (
    input wire logic sysclk,
    input wire logic sim_reset,
    input reg_write_t reg_write,
    input reg_addr_t rd_addr,
    input sim_word_t ign_cycle_cnt,
    input sim_word_t puff_cnt,
    input sim_word_t puff_len,
    output sim_word_t rd_data,
    output sim_word_t ign_period,
    output logic ign_cnt_clear,
    output logic puff_cnt_clear,
    output adc_values_t adc_values
);

    // clear strobes act at the next edge inside the counting blocks.
    assign ign_cnt_clear = reg_write.load && (reg_write.addr == REG_IGN_CYCLE_CNT);
    assign puff_cnt_clear = reg_write.load && (reg_write.addr == REG_PUFF_CNT);

    // writable registers.
    always_ff @(posedge sysclk) begin
        if (sim_reset) begin
            ign_period <= '0;
            adc_values <= '0;
        end else if (reg_write.load) begin
            case (reg_write.addr)
                REG_IGN_PERIOD: ign_period <= reg_write.data;
                REG_ANMUX_BLOCK_TEMP: adc_values.block_temp <= reg_write.data;
                REG_ANMUX_TRANS_TEMP: adc_values.trans_temp <= reg_write.data;
                REG_ADC_MAF: adc_values.maf <= reg_write.data;
                REG_ADC_O2: adc_values.o2 <= reg_write.data;
                REG_ADC_TPS: adc_values.tps <= reg_write.data;
                // count clears and read-only length need no storage here.
                default: ;
            endcase
        end
    end

    // combinational read port.
    always_comb begin
        case (rd_addr)
            REG_IGN_PERIOD: rd_data = ign_period;
            REG_IGN_CYCLE_CNT: rd_data = ign_cycle_cnt;
            REG_PUFF_CNT: rd_data = puff_cnt;
            REG_PUFF_LEN: rd_data = puff_len;
            REG_ANMUX_BLOCK_TEMP: rd_data = adc_values.block_temp;
            REG_ANMUX_TRANS_TEMP: rd_data = adc_values.trans_temp;
            REG_ADC_MAF: rd_data = adc_values.maf;
            REG_ADC_O2: rd_data = adc_values.o2;
            REG_ADC_TPS: rd_data = adc_values.tps;
            // unmapped addresses.
            default: rd_data = '0;
        endcase
    end

    // the host must only write inside the register map.
    a_mapped_write: assert property (@(posedge sysclk) disable iff (sim_reset)
        reg_write.load |-> (reg_write.addr <= REG_ADC_TPS))
        else $error("register write to unmapped address %0d", reg_write.addr);

endmodule

`default_nettype wire

/* logic/ign_pulse_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ign_pulse_gen import car_sim_pkg::*; (
    input wire logic sysclk,
    input wire logic sim_reset,
    input wire logic run,
    input sim_ticks_t ticks,
    input sim_word_t ign_period,
    input wire logic ign_cnt_clear,
    output logic ign_coil,
    output logic ign_end,
    output sim_word_t ign_cycle_cnt
);

    // bits below this one count within the coil pulse.
    localparam int COIL_LSB = $clog2(IGN_PULSE_JIFFIES);

    // jiffies left in the current period.
    sim_word_t ign_count;

    // last jiffy of the period and of the coil pulse.
    assign ign_end = run && ticks.jiffy && (ign_count == '0);

    // coil is on for the final IGN_PULSE_JIFFIES of each period.
    assign ign_coil = (ign_count[15:COIL_LSB] == '0);

    // countdown holds while run is low.
    always_ff @(posedge sysclk) begin
        if (sim_reset)
            ign_count <= '0;
        else if (run && ticks.jiffy)
            ign_count <= ign_end ? ign_period : ign_count - 16'd1;
    end

    // ignition cycle counter that a host write clears.
    always_ff @(posedge sysclk) begin
        if (sim_reset)
            ign_cycle_cnt <= '0;
        else if (ign_cnt_clear)
            ign_cycle_cnt <= '0;
        else if (ign_end)
            ign_cycle_cnt <= ign_cycle_cnt + 16'd1;
    end

endmodule

`default_nettype wire

/* logic/injector_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module injector_monitor import car_sim_pkg::*; #(
    parameter int unsigned PUFF_TIMEOUT_MS = 200
) (
    input wire logic sysclk,
    input wire logic sim_reset,
    input sim_ticks_t ticks,
    input wire logic injector_open,
    input wire logic puff_cnt_clear,
    output logic puff_end,
    output logic puff_timeout,
    output sim_word_t puff_cnt,
    output sim_word_t puff_len
);

    localparam int TO_W = $clog2(PUFF_TIMEOUT_MS + 1);
    localparam logic [TO_W-1:0] TO_LOAD = TO_W'(PUFF_TIMEOUT_MS);

    logic injector_q;
    logic puff_rise;
    logic puff_fall;
    logic [TO_W-1:0] timeout_cnt;

    // edge detection against the previous sample.
    always_ff @(posedge sysclk) begin
        if (sim_reset)
            injector_q <= 1'b0;
        else
            injector_q <= injector_open;
    end

    assign puff_rise = injector_open && !injector_q;
    assign puff_fall = injector_q && !injector_open;

    // end of puff strobe one cycle behind the detected fall.
    always_ff @(posedge sysclk) begin
        if (sim_reset)
            puff_end <= 1'b0;
        else
            puff_end <= puff_fall;
    end

    // puff count that a host write clears.
    always_ff @(posedge sysclk) begin
        if (sim_reset)
            puff_cnt <= '0;
        else if (puff_cnt_clear)
            puff_cnt <= '0;
        else if (puff_fall)
            puff_cnt <= puff_cnt + 16'd1;
    end

    // puff length in microseconds that restarts at each opening.
    always_ff @(posedge sysclk) begin
        if (sim_reset)
            puff_len <= '0;
        else if (puff_rise)
            puff_len <= '0;
        else if (injector_open && ticks.us)
            puff_len <= puff_len + 16'd1;
    end

    // ms countdown since the last puff; zero means timed out.
    always_ff @(posedge sysclk) begin
        if (sim_reset)
            timeout_cnt <= '0;
        else if (puff_fall)
            timeout_cnt <= TO_LOAD;
        else if (ticks.ms && !puff_timeout)
            timeout_cnt <= timeout_cnt - TO_W'(1);
    end

    assign puff_timeout = (timeout_cnt == '0);

    // a puff too long for the length counter cannot be measured.
    a_len_no_wrap: assert property (@(posedge sysclk) disable iff (sim_reset)
        (injector_open && ticks.us && !puff_rise) |-> (puff_len != '1));

endmodule

`default_nettype wire

/* logic/adc_spi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_spi_slave import car_sim_pkg::*; (
    input wire logic sysclk,
    input wire logic sim_reset,
    input wire logic adc_cs_n,
    input wire logic adc_sclk,
    input wire logic adc_saddr,
    input adc_values_t adc_values,
    input anmux_sel_t anmux_ctrl,
    output logic adc_sdat,
    output logic spi_done
);

    logic sclk_q;
    logic cs_n_q;
    logic sclk_rise;
    logic sclk_fall;
    logic cs_n_rise;
    logic cs_n_fall;
    adc_command_u rx_shift;
    sim_word_t tx_shift;
    adc_channel_t channel;
    sim_word_t anmux_word;
    sim_word_t tx_word;

    // previous bus levels with cs_n idle high.
    always_ff @(posedge sysclk) begin
        if (sim_reset) begin
            sclk_q <= 1'b0;
            cs_n_q <= 1'b1;
        end else begin
            sclk_q <= adc_sclk;
            cs_n_q <= adc_cs_n;
        end
    end

    assign sclk_rise = adc_sclk && !sclk_q;
    assign sclk_fall = sclk_q && !adc_sclk;
    assign cs_n_rise = adc_cs_n && !cs_n_q;
    assign cs_n_fall = cs_n_q && !adc_cs_n;

    // end of a transaction.
    assign spi_done = cs_n_rise;

    // analog mux with only the two temperature inputs modeled.
    always_comb begin
        case (anmux_ctrl)
            ANMUX_CH_BLOCK_TEMP: anmux_word = adc_values.block_temp;
            ANMUX_CH_TRANS_TEMP: anmux_word = adc_values.trans_temp;
            default: anmux_word = '0;
        endcase
    end

    // word returned for the channel chosen by the previous command.
    always_comb begin
        case (channel)
            ADC_CH_MAF: tx_word = adc_values.maf;
            ADC_CH_O2: tx_word = adc_values.o2;
            ADC_CH_TPS: tx_word = adc_values.tps;
            ADC_CH_ANMUX: tx_word = anmux_word;
            default: tx_word = '0;
        endcase
    end

    // both shifters are emptied while the slave is deselected.
    always_ff @(posedge sysclk) begin
        if (sim_reset || adc_cs_n) begin
            rx_shift.raw <= '0;
            tx_shift <= '0;
        end else begin
            // MSB goes out first.
            if (cs_n_fall)
                tx_shift <= tx_word;
            else if (sclk_fall)
                tx_shift <= {tx_shift[14:0], 1'b0};
            // command bits arrive MSB first on rising sclk.
            if (sclk_rise)
                rx_shift.raw <= {rx_shift.raw[14:0], adc_saddr};
        end
    end

    assign adc_sdat = tx_shift[15];

    // new command takes effect as cs_n rises.
    always_ff @(posedge sysclk) begin
        if (sim_reset)
            channel <= '0;
        else if (cs_n_rise)
            channel <= rx_shift.fields.channel;
    end

    // holds only if the master gave all 16 clocks before deselecting.
    a_sdat_idle: assert property (@(posedge sysclk) disable iff (sim_reset)
        adc_cs_n |-> !adc_sdat);

endmodule

`default_nettype wire

/* logic/car_sim_top.sv */
`timescale 1ns/1ps
`default_nettype none

module car_sim_top import car_sim_pkg::*; #(
    parameter int unsigned CLK_PER_US = 50,
    parameter int unsigned US_PER_JIFFY = 20,
    parameter int unsigned US_PER_MS = 1000,
    parameter int unsigned PUFF_TIMEOUT_MS = 200
) (
    input wire logic sysclk,
    input wire logic sim_reset,
    input wire logic run,
    input reg_write_t reg_write,
    input reg_addr_t rd_addr,
    input wire logic injector_open,
    input anmux_sel_t anmux_ctrl,
    input wire logic adc_cs_n,
    input wire logic adc_sclk,
    input wire logic adc_saddr,
    output sim_word_t rd_data,
    output logic ign_coil,
    output logic adc_sdat,
    output sim_events_t events
);

    sim_ticks_t ticks;
    sim_word_t ign_period;
    sim_word_t ign_cycle_cnt;
    sim_word_t puff_cnt;
    sim_word_t puff_len;
    logic ign_cnt_clear;
    logic puff_cnt_clear;
    adc_values_t adc_values;

    // shared time base.
    tick_gen #(
        .CLK_PER_US(CLK_PER_US),
        .US_PER_JIFFY(US_PER_JIFFY),
        .US_PER_MS(US_PER_MS)
    ) tick_gen_inst (
        .sysclk(sysclk),
        .sim_reset(sim_reset),
        .ticks(ticks)
    );

    // host registers.
    sim_reg_file sim_reg_file_inst (
        .sysclk(sysclk),
        .sim_reset(sim_reset),
        .reg_write(reg_write),
        .rd_addr(rd_addr),
        .ign_cycle_cnt(ign_cycle_cnt),
        .puff_cnt(puff_cnt),
        .puff_len(puff_len),
        .rd_data(rd_data),
        .ign_period(ign_period),
        .ign_cnt_clear(ign_cnt_clear),
        .puff_cnt_clear(puff_cnt_clear),
        .adc_values(adc_values)
    );

    // ignition source.
    ign_pulse_gen ign_pulse_gen_inst (
        .sysclk(sysclk),
        .sim_reset(sim_reset),
        .run(run),
        .ticks(ticks),
        .ign_period(ign_period),
        .ign_cnt_clear(ign_cnt_clear),
        .ign_coil(ign_coil),
        .ign_end(events.ign_end),
        .ign_cycle_cnt(ign_cycle_cnt)
    );

    // injector watcher.
    injector_monitor #(
        .PUFF_TIMEOUT_MS(PUFF_TIMEOUT_MS)
    ) injector_monitor_inst (
        .sysclk(sysclk),
        .sim_reset(sim_reset),
        .ticks(ticks),
        .injector_open(injector_open),
        .puff_cnt_clear(puff_cnt_clear),
        .puff_end(events.puff_end),
        .puff_timeout(events.puff_timeout),
        .puff_cnt(puff_cnt),
        .puff_len(puff_len)
    );

    // simulated ADC on the target's SPI bus.
    adc_spi_slave adc_spi_slave_inst (
        .sysclk(sysclk),
        .sim_reset(sim_reset),
        .adc_cs_n(adc_cs_n),
        .adc_sclk(adc_sclk),
        .adc_saddr(adc_saddr),
        .adc_values(adc_values),
        .anmux_ctrl(anmux_ctrl),
        .adc_sdat(adc_sdat),
        .spi_done(events.spi_done)
    );

endmodule

`default_nettype wire

/* verif/car_sim_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module car_sim_tb import car_sim_pkg::*; ;

    // scaled-down time base keeps the run short.
    localparam int unsigned CLK_PER_US = 2;
    localparam int unsigned US_PER_JIFFY = 3;
    localparam int unsigned US_PER_MS = 5;
    localparam int unsigned PUFF_TIMEOUT_MS = 4;
    localparam int IGN_WAIT = 200;
    localparam int PUFF_END_WAIT = 10;
    localparam int TIMEOUT_WAIT = (PUFF_TIMEOUT_MS + 1) * US_PER_MS * CLK_PER_US;

    // expected event words; puff_timeout is high whenever no puff is recent.
    localparam sim_events_t EV_IDLE = '{ign_end: 1'b0, puff_end: 1'b0,
        spi_done: 1'b0, puff_timeout: 1'b1};
    localparam sim_events_t EV_SPI_DONE = '{ign_end: 1'b0, puff_end: 1'b0,
        spi_done: 1'b1, puff_timeout: 1'b1};
    localparam sim_events_t EV_PUFF_END = '{ign_end: 1'b0, puff_end: 1'b1,
        spi_done: 1'b0, puff_timeout: 1'b0};

    typedef enum logic [2:0] {OP_REG_WRITE, OP_REG_READ, OP_SPI, OP_IGN, OP_PUFF} op_kind_t;

    // one row of the stimulus table; addr doubles as the ADC channel.
    typedef struct packed {
        op_kind_t op;
        reg_addr_t addr;
        sim_word_t value;
        anmux_sel_t anmux;
        sim_word_t expected;
    } table_entry_t;

    logic sysclk;
    logic sim_reset;
    logic run;
    reg_write_t reg_write;
    reg_addr_t rd_addr;
    logic injector_open;
    anmux_sel_t anmux_ctrl;
    logic adc_cs_n;
    logic adc_sclk;
    logic adc_saddr;
    sim_word_t rd_data;
    logic ign_coil;
    logic adc_sdat;
    sim_events_t events;

    table_entry_t stim_table[$];
    // puffs driven since reset.
    int unsigned puffs_seen;

    car_sim_top #(
        .CLK_PER_US(CLK_PER_US),
        .US_PER_JIFFY(US_PER_JIFFY),
        .US_PER_MS(US_PER_MS),
        .PUFF_TIMEOUT_MS(PUFF_TIMEOUT_MS)
    ) car_sim_top_inst (
        .sysclk(sysclk),
        .sim_reset(sim_reset),
        .run(run),
        .reg_write(reg_write),
        .rd_addr(rd_addr),
        .injector_open(injector_open),
        .anmux_ctrl(anmux_ctrl),
        .adc_cs_n(adc_cs_n),
        .adc_sclk(adc_sclk),
        .adc_saddr(adc_saddr),
        .rd_data(rd_data),
        .ign_coil(ign_coil),
        .adc_sdat(adc_sdat),
        .events(events)
    );

    // 100 ns clock.
    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    // word check with an optional tolerance.
    task automatic compare_word(input string name, input sim_word_t actual,
                                input sim_word_t expected, input int tol);
        int diff;
        diff = int'(actual) - int'(expected);
        if (diff > tol || diff < -tol) begin
            $display("FAILED time=%0t %s: got %h expected %h", $time, name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "word mismatch on %s", name);
        end
    endtask

    task automatic compare_events(input string name, input sim_events_t actual,
                                  input sim_events_t expected);
        if (actual !== expected) begin
            $display("FAILED time=%0t %s: got %b expected %b", $time, name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "event mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("time %0t: gave up waiting for %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "timeout waiting for %s", what);
    endtask

    // host write with load held for one cycle.
    task automatic write_reg(input reg_addr_t addr, input sim_word_t data);
        @(negedge sysclk);
        reg_write = '{load: 1'b1, addr: addr, data: data};
        @(negedge sysclk);
        reg_write.load = 1'b0;
    endtask

    // rd_data is combinational, sampled one half cycle after the address.
    task automatic read_reg(input reg_addr_t addr, output sim_word_t data);
        @(negedge sysclk);
        rd_addr = addr;
        @(posedge sysclk);
        data = rd_data;
    endtask

    // one 16-clock SPI transaction with every level held for two cycles.
    task automatic spi_transfer(input sim_word_t cmd, output sim_word_t word);
        @(negedge sysclk);
        adc_cs_n = 1'b0;
        repeat (2) @(negedge sysclk);
        for (int i = 15; i >= 0; i--) begin
            // sdat is registered, so it is steady at the falling edge.
            word[i] = adc_sdat;
            adc_saddr = cmd[i];
            adc_sclk = 1'b1;
            repeat (2) @(negedge sysclk);
            adc_sclk = 1'b0;
            repeat (2) @(negedge sysclk);
        end
        adc_cs_n = 1'b1;
        adc_saddr = 1'b0;
        @(posedge sysclk);
        compare_events("events at cs_n rise", events, EV_SPI_DONE);
        repeat (2) @(negedge sysclk);
    endtask

    // command transaction, then a second one that returns the sample.
    task automatic spi_read(input adc_channel_t channel, output sim_word_t word);
        adc_command_u cmd;
        sim_word_t unused;
        cmd.raw = '0;
        cmd.fields.channel = channel;
        spi_transfer(cmd.raw, unused);
        spi_transfer(16'h0000, word);
    endtask

    // counts cycles and coil-on cycles up to the next ign_end strobe.
    task automatic wait_ign_end(output int cycles, output int coil_cycles);
        cycles = 0;
        coil_cycles = 0;
        while (1) begin
            @(posedge sysclk);
            cycles++;
            if (ign_coil)
                coil_cycles++;
            if (events.ign_end)
                break;
            if (cycles > IGN_WAIT)
                report_timeout("ign_end strobe");
        end
    endtask

    task automatic check_ignition(input sim_word_t period, input sim_word_t interval);
        int cycles;
        int coil_cycles;
        int coil_expected;
        sim_word_t count;
        // coil is on for the count values below the pulse length.
        if (period < IGN_PULSE_JIFFIES)
            coil_expected = (int'(period) + 1) * US_PER_JIFFY * CLK_PER_US;
        else
            coil_expected = IGN_PULSE_JIFFIES * US_PER_JIFFY * CLK_PER_US;
        write_reg(REG_IGN_PERIOD, period);
        write_reg(REG_IGN_CYCLE_CNT, 16'h0000);
        @(negedge sysclk);
        run = 1'b1;
        // the first strobe may still use a leftover count.
        wait_ign_end(cycles, coil_cycles);
        wait_ign_end(cycles, coil_cycles);
        compare_word("ign_end interval", sim_word_t'(cycles), interval, 0);
        compare_word("ign_coil on cycles", sim_word_t'(coil_cycles),
                     sim_word_t'(coil_expected), 0);
        wait_ign_end(cycles, coil_cycles);
        compare_word("ign_end interval", sim_word_t'(cycles), interval, 0);
        compare_word("ign_coil on cycles", sim_word_t'(coil_cycles),
                     sim_word_t'(coil_expected), 0);
        @(negedge sysclk);
        run = 1'b0;
        read_reg(REG_IGN_CYCLE_CNT, count);
        compare_word("ign_cycle_cnt", count, 16'd3, 0);
        // stopped generator stays silent.
        repeat (IGN_WAIT) begin
            @(posedge sysclk);
            compare_events("events with run low", events, EV_IDLE);
        end
    endtask

    task automatic check_puff(input sim_word_t len_us, input sim_word_t len_expected);
        sim_word_t data;
        int cycles;
        @(negedge sysclk);
        injector_open = 1'b1;
        repeat (len_us * CLK_PER_US) @(negedge sysclk);
        injector_open = 1'b0;
        puffs_seen++;
        cycles = 0;
        while (1) begin
            @(posedge sysclk);
            cycles++;
            if (events.puff_end)
                break;
            if (cycles > PUFF_END_WAIT)
                report_timeout("puff_end strobe");
        end
        compare_events("events at puff end", events, EV_PUFF_END);
        read_reg(REG_PUFF_LEN, data);
        compare_word("puff_len", data, len_expected, 1);
        read_reg(REG_PUFF_CNT, data);
        compare_word("puff_cnt", data, sim_word_t'(puffs_seen), 0);
        cycles = 0;
        while (!events.puff_timeout) begin
            @(posedge sysclk);
            cycles++;
            if (cycles > TIMEOUT_WAIT)
                report_timeout("puff_timeout to rise");
        end
    endtask

    task automatic apply_entry(input table_entry_t entry);
        sim_word_t data;
        case (entry.op)
            OP_REG_WRITE: begin
                write_reg(entry.addr, entry.value);
                read_reg(entry.addr, data);
                compare_word("rd_data", data, entry.expected, 0);
            end
            OP_REG_READ: begin
                read_reg(entry.addr, data);
                compare_word("rd_data", data, entry.expected, 0);
            end
            OP_SPI: begin
                @(negedge sysclk);
                anmux_ctrl = entry.anmux;
                spi_read(adc_channel_t'(entry.addr), data);
                compare_word("adc_sdat word", data, entry.expected, 0);
            end
            OP_IGN: check_ignition(entry.value, entry.expected);
            default: check_puff(entry.value, entry.expected);
        endcase
    endtask

    task automatic add_entry(input op_kind_t op, input reg_addr_t addr, input sim_word_t value,
                             input anmux_sel_t anmux, input sim_word_t expected);
        stim_table.push_back('{op: op, addr: addr, value: value, anmux: anmux,
            expected: expected});
    endtask

    task automatic build_table();
        sim_word_t period;
        sim_word_t maf;
        sim_word_t o2;
        sim_word_t tps;
        sim_word_t blk;
        sim_word_t trn;
        period = sim_word_t'($urandom());
        maf = sim_word_t'($urandom());
        o2 = sim_word_t'($urandom());
        tps = sim_word_t'($urandom());
        blk = sim_word_t'($urandom());
        trn = sim_word_t'($urandom());
        add_entry(OP_REG_WRITE, REG_IGN_PERIOD, period, '0, period);
        add_entry(OP_REG_WRITE, REG_ANMUX_BLOCK_TEMP, blk, '0, blk);
        add_entry(OP_REG_WRITE, REG_ANMUX_TRANS_TEMP, trn, '0, trn);
        add_entry(OP_REG_WRITE, REG_ADC_MAF, maf, '0, maf);
        add_entry(OP_REG_WRITE, REG_ADC_O2, o2, '0, o2);
        add_entry(OP_REG_WRITE, REG_ADC_TPS, tps, '0, tps);
        add_entry(OP_REG_READ, 4'd9, '0, '0, 16'h0000);
        add_entry(OP_REG_READ, 4'd15, '0, '0, 16'h0000);
        add_entry(OP_SPI, reg_addr_t'(ADC_CH_MAF), '0, '0, maf);
        add_entry(OP_SPI, reg_addr_t'(ADC_CH_O2), '0, '0, o2);
        add_entry(OP_SPI, reg_addr_t'(ADC_CH_TPS), '0, '0, tps);
        for (int ch = 0; ch < 4; ch++)
            add_entry(OP_SPI, reg_addr_t'(ch), '0, '0, 16'h0000);
        add_entry(OP_SPI, reg_addr_t'(ADC_CH_ANMUX), '0, ANMUX_CH_BLOCK_TEMP, blk);
        add_entry(OP_SPI, reg_addr_t'(ADC_CH_ANMUX), '0, ANMUX_CH_TRANS_TEMP, trn);
        add_entry(OP_SPI, reg_addr_t'(ADC_CH_ANMUX), '0, 4'd9, 16'h0000);
        // strobe spacing is (period+1) jiffies in sysclk cycles.
        add_entry(OP_IGN, '0, 16'd2, '0, sim_word_t'(3 * US_PER_JIFFY * CLK_PER_US));
        add_entry(OP_IGN, '0, 16'd5, '0, sim_word_t'(6 * US_PER_JIFFY * CLK_PER_US));
        // long period lets the coil drop between pulses.
        add_entry(OP_IGN, '0, 16'd20, '0, sim_word_t'(21 * US_PER_JIFFY * CLK_PER_US));
        add_entry(OP_PUFF, '0, 16'd3, '0, 16'd3);
        add_entry(OP_PUFF, '0, 16'd7, '0, 16'd7);
        // writes to the count addresses clear them.
        add_entry(OP_REG_WRITE, REG_PUFF_CNT, 16'h1234, '0, 16'h0000);
        add_entry(OP_REG_WRITE, REG_IGN_CYCLE_CNT, 16'h4321, '0, 16'h0000);
    endtask

    initial begin
        void'($urandom(74));
        puffs_seen = 0;
        sim_reset = 1'b1;
        run = 1'b0;
        reg_write = '0;
        rd_addr = '0;
        injector_open = 1'b0;
        anmux_ctrl = '0;
        adc_cs_n = 1'b1;
        adc_sclk = 1'b0;
        adc_saddr = 1'b0;
        build_table();
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        sim_reset = 1'b0;
        foreach (stim_table[i])
            apply_entry(stim_table[i]);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/car_sim_pkg.sv
logic/tick_gen.sv
logic/sim_reg_file.sv
logic/ign_pulse_gen.sv
logic/injector_monitor.sv
logic/adc_spi_slave.sv
logic/car_sim_top.sv
verif/car_sim_tb.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f filelist.f --top-module car_sim_tb -Mdir obj_dir

run: compile
	./obj_dir/Vcar_sim_tb

clean:
	rm -rf obj_dir
